/* Makefile */
VERILATOR ?= verilator
TOP ?= decoderTb
FILELIST ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing
PASS_TEXT ?= All tests passed!

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -qF "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

/* classify/opcodeClassifier.sv */
`timescale 1ns/1ps

module opcodeClassifier (
	input logic clock,
	input logic rstN,
	input logic inValid,
	output logic inReady,
	input decodePkg::instrWord_u inWord,
	output logic midValid,
	input logic midReady,
	output decodePkg::classified_s midOp
);
	import decodePkg::*;

	classified_s cls;
	logic [15:0] opKey;
	logic isFx;
	logic isDisp;
	logic isRegBr;
	logic [1:0] brSel;

	function automatic uCmd_t stCmd(input logic [1:0] size);
		case (size)
			2'd0: stCmd = cmdMovbRm;
			2'd1: stCmd = cmdMovwRm;
			2'd2: stCmd = cmdMovlRm;
			default: stCmd = cmdMovqRm;
		endcase
	endfunction

	function automatic uCmd_t ldCmd(input logic [1:0] size, input logic uns);
		case (size)
			2'd0: ldCmd = uns ? cmdMovubMr : cmdMovbMr;
			2'd1: ldCmd = uns ? cmdMovuwMr : cmdMovwMr;
			2'd2: ldCmd = uns ? cmdMovulMr : cmdMovlMr;
			default: ldCmd = uns ? cmdMovulMr : cmdMovqMr;
		endcase
	endfunction

	// unsigned quad load falls back to long
	function automatic bty_e ldBty(input logic [1:0] size, input logic uns);
		ldBty = (size == 2'd3 && uns) ? btySl : bty_e'({1'b0, size});
	endfunction

	always_comb begin
		opKey = {inWord.r.opc, inWord.r.n, inWord.r.m};
		isFx = (inWord.r.prefix ==? fxPrefix);
		isDisp = (inWord.d.opc[3:2] == 2'b11);	// Cddd..Fddd
		isRegBr = (opKey[15:2] == 14'b0011_0000_0001_00);	// 3010..3013
		brSel = isDisp ? inWord.d.opc[1:0] : opKey[1:0];

		cls.word = inWord;
		cls.uCmd = cmdInvop;
		cls.form = formInv;
		cls.ity = itySb;
		cls.bty = btySb;
		cls.cc = ccAlways;

		if (isDisp || isRegBr) begin
			cls.form = isDisp ? formPcDisp : formRegPc;
			cls.uCmd = (brSel == 2'b01) ? cmdBsr : cmdBra;
			cls.cc = brSel[1] ? cc_e'(brSel) : ccAlways;
			cls.bty = btySw;
		end else begin
			casez (opKey)
				16'b0000_01??_????_????: begin	// stores 04..07 and lea when q
					cls.uCmd = inWord.r.q ? cmdLea : stCmd(opKey[9:8]);
					cls.form = inWord.r.q ? formLdIdx : formStIdx;
					cls.bty = bty_e'({1'b0, opKey[9:8]});
					cls.ity = ityUb;
				end
				16'b0000_11??_????_????: begin	// 0C..0F
					cls.uCmd = ldCmd(opKey[9:8], inWord.r.q);
					cls.form = formLdIdx;
					cls.bty = ldBty(opKey[9:8], inWord.r.q);
					cls.ity = ityUb;
				end
				16'h10??, 16'h11??, 16'h12??, 16'h15??, 16'h16??, 16'h17??: begin
					cls.form = formRegReg;
					case (opKey[11:8])
						4'h0: cls.uCmd = cmdAdd3;
						4'h1: cls.uCmd = cmdSub3;
						4'h2: cls.uCmd = cmdMul3;
						4'h5: cls.uCmd = cmdAnd3;
						4'h6: cls.uCmd = cmdOr3;
						default: cls.uCmd = cmdXor3;
					endcase
				end
				16'h19??: begin
					cls.form = formRegReg;
					case (inWord.r.o)
						4'h0: cls.uCmd = cmdAdd3;
						4'h1: cls.uCmd = cmdSub3;
						4'h2: cls.uCmd = cmdAdc3;
						4'h3: cls.uCmd = cmdSbb3;
						4'h4: cls.uCmd = inWord.r.q ? cmdTstq : cmdTst;
						4'h5: cls.uCmd = cmdAnd3;
						4'h6: cls.uCmd = cmdOr3;
						4'h7: cls.uCmd = cmdXor3;
						4'h8: cls.uCmd = cmdMovRr;
						4'h9: cls.uCmd = cmdMuls;
						4'hC: cls.uCmd = inWord.r.q ? cmdCmpQEq : cmdCmpEq;
						4'hD: cls.uCmd = inWord.r.q ? cmdCmpQHi : cmdCmpHi;
						4'hE: cls.uCmd = inWord.r.q ? cmdCmpQGt : cmdCmpGt;
						4'hF: cls.uCmd = cmdMulu;
						default: cls.form = formInv;	// control moves
					endcase
					// two-operand ops reuse n as first source
					if (inWord.r.o <= 4'h7 && inWord.r.o != 4'h4)
						cls.ity = ityNb;
				end
				16'h1B??: begin
					cls.cc = cc_e'({1'b1, inWord.r.extI});
					if (inWord.r.o[3]) begin
						cls.uCmd = ldCmd(inWord.r.o[1:0], inWord.r.q);
						cls.bty = ldBty(inWord.r.o[1:0], inWord.r.q);
						cls.form = inWord.r.o[2] ? formLdIdx : formLd;
					end else begin
						cls.uCmd = stCmd(inWord.r.o[1:0]);
						cls.bty = bty_e'({1'b0, inWord.r.o[1:0]});
						cls.form = inWord.r.o[2] ? formStIdx : formSt;
					end
				end
				default: begin
				end
			endcase
		end

		if (!isFx) begin
			cls.uCmd = cmdInvop;
			cls.form = formInv;
		end
	end

	//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// stage 1 slot
	//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign inReady = !midValid || midReady;

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN)
			midValid <= 1'b0;
		else if (inReady)
			midValid <= inValid;
	end

	always_ff @(posedge clock) begin
		if (inValid && inReady)
			midOp <= cls;
	end

endmodule

/* common/decodePkg.sv */
package decodePkg;

	//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// widths and registers
	//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	typedef logic [5:0] regId_t;
	typedef logic [7:0] uCmd_t;
	typedef logic [32:0] imm_t;

	localparam regId_t regDlr = 6'h20;
	localparam regId_t regPc = 6'h30;
	localparam regId_t regGbr = 6'h32;
	localparam regId_t regTbr = 6'h33;
	localparam regId_t regZzr = 6'h3F;

	localparam logic [1:0] ixRri = 2'b00;
	localparam logic [7:0] fxPrefix = 8'b11?10?00;	// bits 13 and 10 free

	//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// micro-command codes
	//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	localparam uCmd_t cmdInvop = 8'h00;
	localparam uCmd_t cmdMovRr = 8'h01;
	localparam uCmd_t cmdAdd3 = 8'h10;
	localparam uCmd_t cmdSub3 = 8'h11;
	localparam uCmd_t cmdMul3 = 8'h12;
	localparam uCmd_t cmdAdc3 = 8'h13;
	localparam uCmd_t cmdSbb3 = 8'h14;
	localparam uCmd_t cmdAnd3 = 8'h15;
	localparam uCmd_t cmdOr3 = 8'h16;
	localparam uCmd_t cmdXor3 = 8'h17;
	localparam uCmd_t cmdTst = 8'h18;
	localparam uCmd_t cmdTstq = 8'h19;
	localparam uCmd_t cmdMuls = 8'h1A;
	localparam uCmd_t cmdMulu = 8'h1B;
	localparam uCmd_t cmdCmpEq = 8'h20;
	localparam uCmd_t cmdCmpHi = 8'h21;
	localparam uCmd_t cmdCmpGt = 8'h22;
	localparam uCmd_t cmdCmpQEq = 8'h24;
	localparam uCmd_t cmdCmpQHi = 8'h25;
	localparam uCmd_t cmdCmpQGt = 8'h26;
	localparam uCmd_t cmdLea = 8'h30;
	localparam uCmd_t cmdMovbRm = 8'h31;	// stores
	localparam uCmd_t cmdMovwRm = 8'h32;
	localparam uCmd_t cmdMovlRm = 8'h33;
	localparam uCmd_t cmdMovqRm = 8'h34;
	localparam uCmd_t cmdMovbMr = 8'h38;	// loads
	localparam uCmd_t cmdMovwMr = 8'h39;
	localparam uCmd_t cmdMovlMr = 8'h3A;
	localparam uCmd_t cmdMovqMr = 8'h3B;
	localparam uCmd_t cmdMovubMr = 8'h3C;
	localparam uCmd_t cmdMovuwMr = 8'h3D;
	localparam uCmd_t cmdMovulMr = 8'h3E;
	localparam uCmd_t cmdBra = 8'h40;
	localparam uCmd_t cmdBsr = 8'h41;
	localparam uCmd_t cmdJmp = 8'h42;
	localparam uCmd_t cmdJsr = 8'h43;

	//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// decode enums
	//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	typedef enum logic [2:0] {
		formInv,
		formRegReg,
		formStIdx,
		formLdIdx,
		formSt,
		formLd,
		formRegPc,
		formPcDisp
	} form_e;

	typedef enum logic [1:0] {itySb, ityNb, ityUb} ity_e;
	typedef enum logic [2:0] {btySb, btySw, btySl, btySq} bty_e;
	typedef enum logic [1:0] {ccAlways = 2'b00, ccTrue = 2'b10, ccFalse = 2'b11} cc_e;

	typedef struct packed {
		cc_e cc;
		logic [1:0] ixMode;
		logic ld;
		bty_e bty;
	} uIxt_t;

	//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// instruction word read two ways
	//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	typedef struct packed {
		logic [7:0] opc;
		logic [3:0] n;
		logic [3:0] m;
		logic [7:0] prefix;
		logic q;
		logic extN;
		logic extM;
		logic extI;
		logic [3:0] o;
	} regView_s;

	typedef struct packed {
		logic [3:0] opc;
		logic [11:0] dispLo;
		logic [7:0] prefix;
		logic [7:0] dispHi;	// sign lives in bit 7
	} dispView_s;

	typedef union packed {
		regView_s r;
		dispView_s d;
	} instrWord_u;

	typedef struct packed {
		instrWord_u word;
		uCmd_t uCmd;
		form_e form;
		ity_e ity;
		bty_e bty;
		cc_e cc;
	} classified_s;

	typedef struct packed {
		uCmd_t uCmd;
		regId_t regN;
		regId_t regM;
		regId_t regO;
		imm_t imm;
		uIxt_t uIxt;
	} microOp_s;

endpackage

/* operand/memBaseSelect.sv */
`timescale 1ns/1ps

module memBaseSelect (
	input decodePkg::regId_t baseField,
	input decodePkg::regId_t idxField,
	output decodePkg::regId_t baseReg,
	output decodePkg::regId_t idxReg,
	output logic sizeOverride
);
	import decodePkg::*;

	logic baseLow;	// base field names R0 or R1
	logic idxR1;

	assign baseLow = (baseField[5:1] == 5'b10000);
	assign idxR1 = (idxField[5:1] == 5'b10000) && idxField[0];
	assign sizeOverride = baseLow;

	always_comb begin
		baseReg = baseField;
		idxReg = idxField;
		if (baseLow) begin
			case ({baseField[0], idxR1})
				2'b11: begin
					baseReg = regTbr;
					idxReg = regDlr;
				end
				2'b10: baseReg = regGbr;
				2'b01: begin
					baseReg = regDlr;
					idxReg = regZzr;
				end
				default: baseReg = regPc;	// pc-relative with index
			endcase
		end
	end

endmodule

/* operand/operandMapper.sv */
`timescale 1ns/1ps

module operandMapper (
	input logic clock,
	input logic rstN,
	input logic midValid,
	output logic midReady,
	input decodePkg::classified_s midOp,
	output logic outValid,
	input logic outReady,
	output decodePkg::microOp_s outOp
);
	import decodePkg::*;

	regId_t dflN;
	regId_t dflM;
	regId_t dflO;
	regId_t baseField;
	regId_t baseReg;
	regId_t idxReg;
	logic sizeOverride;
	logic isIdx;
	logic isLd;
	imm_t dispImm;
	microOp_s nextOp;

	// top three bits zero or field F picks the high bank
	function automatic regId_t dflReg(input logic [3:0] field, input logic ext);
		dflReg = {(field[3:1] == 3'b000) || (field == 4'hF), ext, field};
	endfunction

	assign dflN = dflReg(midOp.word.r.n, midOp.word.r.extN);
	assign dflM = dflReg(midOp.word.r.m, midOp.word.r.extM);
	assign dflO = dflReg(midOp.word.r.o, midOp.word.r.extI);
	assign baseField = (midOp.form == formStIdx) ? dflN : dflM;	// stores carry base in n
	assign dispImm = {{13{midOp.word.d.dispHi[7]}}, midOp.word.d.dispHi, midOp.word.d.dispLo};

	memBaseSelect u0 (
		.baseField(baseField),
		.idxField(dflO),
		.baseReg(baseReg),
		.idxReg(idxReg),
		.sizeOverride(sizeOverride)
	);

	always_comb begin
		isIdx = midOp.form inside {formStIdx, formLdIdx};
		isLd = midOp.form inside {formLdIdx, formLd};
		nextOp.uCmd = midOp.uCmd;
		nextOp.regN = regZzr;
		nextOp.regM = regZzr;
		nextOp.regO = regZzr;
		nextOp.imm = '0;
		nextOp.uIxt = '0;
		case (midOp.form)
			formRegReg: begin
				nextOp.regN = dflN;
				nextOp.regM = (midOp.ity == ityNb) ? dflN : dflM;
				nextOp.regO = (midOp.ity == ityNb) ? dflM : dflO;
			end
			formStIdx, formLdIdx, formSt, formLd: begin
				nextOp.uIxt = {midOp.cc, ixRri, isLd, midOp.bty};
				if (isIdx && midOp.ity == ityUb) begin
					nextOp.regN = isLd ? dflN : dflM;
					nextOp.regM = baseReg;
					nextOp.regO = idxReg;
					if (sizeOverride)
						nextOp.uIxt.bty = btySb;
				end else begin
					nextOp.regN = dflN;
					nextOp.regM = dflM;
					nextOp.regO = regDlr;
				end
			end
			formRegPc: begin
				nextOp.regM = regPc;
				nextOp.regO = dflO;
				nextOp.uIxt = {midOp.cc, ixRri, 1'b1, midOp.bty};
			end
			formPcDisp: begin
				nextOp.imm = dispImm;
				nextOp.uIxt = {midOp.cc, ixRri, 1'b1, midOp.bty};
			end
			default: nextOp.uCmd = cmdInvop;
		endcase
	end

	// output slot
	assign midReady = !outValid || outReady;

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN)
			outValid <= 1'b0;
		else if (midReady)
			outValid <= midValid;
	end

	always_ff @(posedge clock) begin
		if (midValid && midReady)
			outOp <= nextOp;
	end

endmodule

/* rtl/decoderTop.sv */
`timescale 1ns/1ps

module decoderTop (
	input logic clock,
	input logic rstN,
	input logic inValid,
	output logic inReady,
	input decodePkg::instrWord_u inWord,
	output logic outValid,
	input logic outReady,
	output decodePkg::microOp_s outOp
);
	import decodePkg::*;

	// stage 1 to stage 2 link
	logic midValid;
	logic midReady;
	classified_s midOp;

	opcodeClassifier u0 (
		.clock(clock),
		.rstN(rstN),
		.inValid(inValid),
		.inReady(inReady),
		.inWord(inWord),
		.midValid(midValid),
		.midReady(midReady),
		.midOp(midOp)
	);

	operandMapper u1 (
		.clock(clock),
		.rstN(rstN),
		.midValid(midValid),
		.midReady(midReady),
		.midOp(midOp),
		.outValid(outValid),
		.outReady(outReady),
		.outOp(outOp)
	);

endmodule

/* test/decodeVectors.svh */
task automatic fillTable();
	// each row gives input word, command, regN, regM, regO, immediate and extension byte

	// ALU with itySb and ityNb
	addVector(32'h1023_D004, cmdAdd3, 6'h02, 6'h03, 6'h04, '0, 8'h00);
	addVector(32'h1145_D07A, cmdSub3, 6'h14, 6'h15, 6'h1A, '0, 8'h00);
	addVector(32'h1201_D0F3, cmdMul3, 6'h30, 6'h31, 6'h13, '0, 8'h00);
	addVector(32'h17F2_D00F, cmdXor3, 6'h2F, 6'h02, 6'h2F, '0, 8'h00);
	addVector(32'h1923_D00C, cmdCmpEq, 6'h02, 6'h03, 6'h0C, '0, 8'h00);
	addVector(32'h1923_D08D, cmdCmpQHi, 6'h02, 6'h03, 6'h0D, '0, 8'h00);
	addVector(32'h1956_D001, cmdSub3, 6'h05, 6'h05, 6'h06, '0, 8'h00);
	addVector(32'h1934_D084, cmdTstq, 6'h03, 6'h04, 6'h04, '0, 8'h00);
	addVector(32'h1023_F404, cmdAdd3, 6'h02, 6'h03, 6'h04, '0, 8'h00);	// free prefix bits set

	// loads, stores, lea
	addVector(32'h0645_D006, cmdMovlRm, 6'h05, 6'h04, 6'h06, '0, {ccAlways, ixRri, 1'b0, btySl});
	addVector(32'h0645_D086, cmdLea, 6'h04, 6'h05, 6'h06, '0, {ccAlways, ixRri, 1'b1, btySl});
	addVector(32'h0E78_D009, cmdMovlMr, 6'h07, 6'h08, 6'h09, '0, {ccAlways, ixRri, 1'b1, btySl});
	addVector(32'h0D78_D089, cmdMovuwMr, 6'h07, 6'h08, 6'h09, '0, {ccAlways, ixRri, 1'b1, btySw});
	addVector(32'h0F78_D089, cmdMovulMr, 6'h07, 6'h08, 6'h09, '0, {ccAlways, ixRri, 1'b1, btySl});
	addVector(32'h1B23_D01E, cmdMovlMr, 6'h02, 6'h03, regDlr, '0, {ccFalse, ixRri, 1'b1, btySl});
	addVector(32'h1B45_D001, cmdMovwRm, 6'h04, 6'h05, regDlr, '0, {ccTrue, ixRri, 1'b0, btySw});

	// R0/R1 base remapping
	addVector(32'h0E31_D001, cmdMovlMr, 6'h03, regTbr, regDlr, '0, {ccAlways, ixRri, 1'b1, btySb});
	addVector(32'h0E31_D005, cmdMovlMr, 6'h03, regGbr, 6'h05, '0, {ccAlways, ixRri, 1'b1, btySb});
	addVector(32'h0E30_D001, cmdMovlMr, 6'h03, regDlr, regZzr, '0, {ccAlways, ixRri, 1'b1, btySb});
	addVector(32'h0E30_D007, cmdMovlMr, 6'h03, regPc, 6'h07, '0, {ccAlways, ixRri, 1'b1, btySb});
	addVector(32'h0710_D002, cmdMovqRm, regDlr, regGbr, 6'h02, '0, {ccAlways, ixRri, 1'b0, btySb});

	// register and displacement branches
	addVector(32'h3010_D005, cmdBra, regZzr, regPc, 6'h05, '0, {ccAlways, ixRri, 1'b1, btySw});
	addVector(32'h3011_D013, cmdBsr, regZzr, regPc, 6'h13, '0, {ccAlways, ixRri, 1'b1, btySw});
	addVector(32'h3012_D004, cmdBra, regZzr, regPc, 6'h04, '0, {ccTrue, ixRri, 1'b1, btySw});
	addVector(32'h3013_D004, cmdBra, regZzr, regPc, 6'h04, '0, {ccFalse, ixRri, 1'b1, btySw});
	addVector(32'hC123_D045, cmdBra, regZzr, regZzr, regZzr, 33'h0_0004_5123,
		{ccAlways, ixRri, 1'b1, btySw});
	addVector(32'hDFFF_D0FF, cmdBsr, regZzr, regZzr, regZzr, 33'h1_FFFF_FFFF,
		{ccAlways, ixRri, 1'b1, btySw});
	addVector(32'hE800_D080, cmdBra, regZzr, regZzr, regZzr, 33'h1_FFF8_0800,
		{ccTrue, ixRri, 1'b1, btySw});
	addVector(32'hF001_D000, cmdBra, regZzr, regZzr, regZzr, 33'h0_0000_0001,
		{ccFalse, ixRri, 1'b1, btySw});

	// bad prefix or unkept opcode
	addVector(32'h1023_0004, cmdInvop, regZzr, regZzr, regZzr, '0, 8'h00);
	addVector(32'h1023_D104, cmdInvop, regZzr, regZzr, regZzr, '0, 8'h00);
	addVector(32'h2023_D004, cmdInvop, regZzr, regZzr, regZzr, '0, 8'h00);
	addVector(32'h1923_D00A, cmdInvop, regZzr, regZzr, regZzr, '0, 8'h00);
	addVector(32'hC123_0045, cmdInvop, regZzr, regZzr, regZzr, '0, 8'h00);
endtask

/* test/decoderTb.sv */
`timescale 1ns/1ps

module decoderTb;
	import decodePkg::*;

	localparam int resetCycles = 8;
	localparam int timeoutCycles = 50;

	logic clock;
	logic rstN;
	logic inValid;
	logic inReady;
	instrWord_u inWord;
	logic outValid;
	logic outReady;
	microOp_s outOp;

	logic [31:0] vecWord[$];
	microOp_s vecExp[$];

	decoderTop dut0 (
		.clock(clock),
		.rstN(rstN),
		.inValid(inValid),
		.inReady(inReady),
		.inWord(inWord),
		.outValid(outValid),
		.outReady(outReady),
		.outOp(outOp)
	);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// helpers
	//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic abortRun(input string why);
		$display("%s", why);
		$display("Test failures found");
		$fatal(1);
	endtask

	task automatic checkEqual(input logic [95:0] got, input logic [95:0] exp, input string what);
		if (got !== exp)
			abortRun($sformatf("Error at %0t ns: %s got %h expected %h", $time, what, got, exp));
	endtask

	task automatic addVector(input logic [31:0] word, input uCmd_t cmd, input regId_t n,
		input regId_t m, input regId_t o, input imm_t imm, input logic [7:0] ixt);
		microOp_s e;
		e.uCmd = cmd;
		e.regN = n;
		e.regM = m;
		e.regO = o;
		e.imm = imm;
		e.uIxt = ixt;
		vecWord.push_back(word);
		vecExp.push_back(e);
	endtask

	`include "decodeVectors.svh"

	// starts and ends 1 ns after an edge
	task automatic driveTable();
		int idx;
		int waitCycles;
		idx = 0;
		while (idx < vecWord.size()) begin
			inValid = 1'b1;
			inWord = vecWord[idx];
			waitCycles = 0;
			@(posedge clock);
			while (!inReady) begin
				waitCycles++;
				if (waitCycles > timeoutCycles)
					abortRun($sformatf("timeout: inReady stayed low for entry %0d", idx));
				@(posedge clock);
			end
			#1;
			idx++;
		end
		inValid = 1'b0;
	endtask

	task automatic collectTable(input bit stall);
		int idx;
		int idle;
		idx = 0;
		idle = 0;
		while (idx < vecExp.size()) begin
			outReady = stall ? ($urandom % 3 != 0) : 1'b1;	// low about a third of the time
			@(posedge clock);
			if (outValid && outReady) begin
				checkEqual(96'(outOp), 96'(vecExp[idx]), $sformatf("entry %0d", idx));
				idx++;
				idle = 0;
			end else begin
				idle++;
				if (idle > timeoutCycles)
					abortRun($sformatf("timeout: no output transfer for entry %0d", idx));
			end
			#1;
		end
	endtask

	// nothing may follow the last entry
	task automatic drainCheck();
		outReady = 1'b1;
		repeat (4) begin
			@(posedge clock);
			checkEqual(96'(outValid), 96'(0), "outValid after last entry");
			#1;
		end
	endtask

	//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// main sequence
	//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	initial begin
		int round;
		void'($urandom(59));
		rstN = 1'b0;
		inValid = 1'b0;
		inWord = '0;
		outReady = 1'b0;
		fillTable();
		repeat (resetCycles) @(posedge clock);
		#1;
		rstN = 1'b1;
		@(posedge clock);
		checkEqual(96'({outValid, inReady}), 96'(2'b01), "handshake flags after reset");
		#1;
		// round 0 streams freely and round 1 stalls at random
		for (round = 0; round < 2; round++) begin
			fork
				driveTable();
				collectTable(round == 1);
			join
			drainCheck();
		end
		$display("All tests passed!");
		$finish;
	end

endmodule

/* verilog.f */
+incdir+test
common/decodePkg.sv
classify/opcodeClassifier.sv
operand/memBaseSelect.sv
operand/operandMapper.sv
rtl/decoderTop.sv
test/decoderTb.sv
